// ==== src/trs80_bus_pkg.sv ====
package trs80_bus_pkg;

  // ==========================================================================
  // Clocking and address map
  // ==========================================================================

  // Clock enable divider exponent, enable is top bit of a CPU_SPEED+1 counter
  localparam int CPU_SPEED = 1;

  // Lowest CPU address open to memory writes
  localparam logic [15:0] RAM_BASE = 16'h3000;

  // I/O port numbers, matched on low address byte
  localparam logic [7:0] PORT_GAME = 8'h04;
  localparam logic [7:0] PORT_CASS = 8'hFF;

  // Memory address widths
  localparam int ROM_AW = 14;
  localparam int RAM_AW = 16;

  // ==========================================================================
  // Bus types
  // ==========================================================================

  // Z80 side bus, strobes active low
  typedef struct packed {
    logic        n_rd;
    logic        n_wr;
    logic        n_mreq;
    logic        n_iorq;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } cpu_bus_t;

  // Kind of bus cycle in progress
  typedef enum logic [2:0] {
    cyc_idle,
    cyc_mem_rd,
    cyc_mem_wr,
    cyc_io_rd,
    cyc_io_wr
  } cycle_kind_e;

  // Decoded selects handed to the devices
  typedef struct packed {
    cycle_kind_e kind;
    logic        game_sel;
    logic        cass_sel;
    logic        ram_wr_ok;
  } dev_sel_t;

  // Sound output level
  typedef logic [3:0] audio_t;

endpackage

// ==== src/trs80_host_pkg.sv ====
package trs80_host_pkg;

  // ==========================================================================
  // Host load port
  // ==========================================================================

  // Decoded host access, strobes active high
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [31:0] addr;
    logic [7:0]  data;
  } host_wr_t;

  // Region, top byte of host address
  typedef enum logic [7:0] {
    region_ram  = 8'h00,
    region_ctrl = 8'hFF
  } host_region_e;

  // ==========================================================================
  // Control register bits
  // ==========================================================================

  // Holds CPU in reset while set
  localparam int CTRL_RESET_BIT = 0;

  // Hands RAM to host and stalls CPU while set
  localparam int CTRL_LOAD_BIT = 1;

endpackage

// ==== src/cpu_timing.sv ====
`timescale 1ns/1ns

module cpu_timing
  import trs80_bus_pkg::*;
(
  input  logic clk_cpu,
  input  logic pwr_up_reset_n,
  input  logic i_btn_reset_n,
  input  logic i_ctrl_reset,
  output logic o_cpu_ce,
  output logic o_cpu_reset_n
);

  // ==========================================================================
  // Clock enable divider
  // ==========================================================================

  // Free-running, top bit high for half the period
  logic [CPU_SPEED:0] ce_count;

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      ce_count <= '0;
    end else begin
      ce_count <= ce_count + 1'b1;
    end
  end

  // Two cycles high out of four at CPU_SPEED of 1
  assign o_cpu_ce = ce_count[CPU_SPEED];

  // ==========================================================================
  // CPU reset merge
  // ==========================================================================

  // Power-up, button and control bit all hold the CPU
  // Registered so the CPU sees one clean edge
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_cpu_reset_n <= 1'b0;
    end else begin
      o_cpu_reset_n <= i_btn_reset_n & ~i_ctrl_reset;
    end
  end

endmodule

// ==== src/bus_decode.sv ====
`timescale 1ns/1ns

module bus_decode
  import trs80_bus_pkg::*;
(
  input  cpu_bus_t i_cpu_bus,
  output dev_sel_t o_sel
);

  // Combined strobes, active high
  logic mem_rd;
  logic mem_wr;
  logic io_rd;
  logic io_wr;

  assign mem_rd = ~i_cpu_bus.n_mreq & ~i_cpu_bus.n_rd;
  assign mem_wr = ~i_cpu_bus.n_mreq & ~i_cpu_bus.n_wr;
  assign io_rd  = ~i_cpu_bus.n_iorq & ~i_cpu_bus.n_rd;
  assign io_wr  = ~i_cpu_bus.n_iorq & ~i_cpu_bus.n_wr;

  // Cycle classification
  always_comb begin
    if (mem_rd) begin
      o_sel.kind = cyc_mem_rd;
    end else if (mem_wr) begin
      o_sel.kind = cyc_mem_wr;
    end else if (io_rd) begin
      o_sel.kind = cyc_io_rd;
    end else if (io_wr) begin
      o_sel.kind = cyc_io_wr;
    end else begin
      o_sel.kind = cyc_idle;
    end
  end

  // Port selects from low address byte only
  // Device checks the cycle kind itself
  assign o_sel.game_sel = (i_cpu_bus.addr[7:0] == PORT_GAME);
  assign o_sel.cass_sel = (i_cpu_bus.addr[7:0] == PORT_CASS);

  // Anything below RAM_BASE is ROM space, never written by the CPU
  assign o_sel.ram_wr_ok = mem_wr & (i_cpu_bus.addr >= RAM_BASE);

endmodule

// ==== src/io_ports.sv ====
`timescale 1ns/1ns

module io_ports
  import trs80_bus_pkg::*;
(
  input  logic              clk_cpu,
  input  logic              pwr_up_reset_n,
  input  logic              i_cpu_ce,
  input  dev_sel_t          i_sel,
  input  logic [7:0]        i_wdata,
  input  logic [7:0]        i_rom_data,
  input  logic [7:0]        i_ram_data,
  output logic [ROM_AW-1:0] o_rom_addr,
  output logic [7:0]        o_rdata,
  output audio_t            o_audio
);

  // Port cycle qualifiers
  logic io_rd;
  logic game_wr;
  logic game_rd;
  logic cass_wr;

  // Registered I/O read, for start-of-read detection
  logic io_rd_q;

  // Cassette motor bit as last written
  logic tape_motor;

  // Byte fetched for the current IN 4
  logic [7:0] game_latch;

  assign io_rd   = (i_sel.kind == cyc_io_rd);
  assign game_rd = io_rd & i_sel.game_sel;
  assign game_wr = (i_sel.kind == cyc_io_wr) & i_sel.game_sel;
  assign cass_wr = (i_sel.kind == cyc_io_wr) & i_sel.cass_sel;

  // ==========================================================================
  // Game stream and tape
  // ==========================================================================

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_rom_addr <= '0;
      tape_motor <= 1'b0;
      io_rd_q    <= 1'b0;
    end else if (i_cpu_ce) begin
      // OUT 4 rewinds the stream
      if (game_wr) begin
        o_rom_addr <= '0;
      end

      // Motor switching on also rewinds
      if (cass_wr) begin
        if (i_wdata[2] && !tape_motor) begin
          o_rom_addr <= '0;
        end
        tape_motor <= i_wdata[2];
      end

      // IN 4, step once per read cycle
      io_rd_q <= io_rd;
      if (game_rd && !io_rd_q) begin
        o_rom_addr <= o_rom_addr + 1'b1;
      end
    end
  end

  // ROM data already valid for the held address
  always_ff @(posedge clk_cpu) begin
    if (i_cpu_ce && game_rd && !io_rd_q) begin
      game_latch <= i_rom_data;
    end
  end

  // ==========================================================================
  // Sound
  // ==========================================================================

  // Not tied to the enable, follows any cassette write
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_audio <= '0;
    end else if (cass_wr) begin
      case (i_wdata[1:0])
        2'b00:   o_audio <= 4'd4;
        2'b01:   o_audio <= 4'd8;
        2'b10:   o_audio <= 4'd0;
        default: o_audio <= 4'd4;
      endcase
    end
  end

  // ==========================================================================
  // CPU read data
  // ==========================================================================

  // Game latch on IN 4, RAM for everything else
  assign o_rdata = game_rd ? game_latch : i_ram_data;

endmodule

// ==== src/game_rom.sv ====
`timescale 1ns/1ns

module game_rom
  import trs80_bus_pkg::*;
(
  input  logic              clk_cpu,
  input  logic [ROM_AW-1:0] i_addr,
  output logic [7:0]        o_data
);

  // 16 KB of game data
  logic [7:0] rom_mem [2**ROM_AW];

  // Unlisted entries stay zero
  initial begin
    for (int i = 0; i < 2**ROM_AW; i++) begin
      rom_mem[i] = 8'h00;
    end
    $readmemh("game_rom.mem", rom_mem);
  end

  // One cycle read
  always_ff @(posedge clk_cpu) begin
    o_data <= rom_mem[i_addr];
  end

endmodule

// ==== src/system_ram.sv ====
`timescale 1ns/1ns

module system_ram
  import trs80_bus_pkg::*;
  import trs80_host_pkg::*;
(
  input  logic     clk_cpu,
  input  logic     i_cpu_ce,
  input  dev_sel_t i_sel,
  input  cpu_bus_t i_cpu_bus,
  input  host_wr_t i_host,
  input  logic     i_load_mode,
  output logic [7:0] o_data
);

  // 64 KB system memory
  logic [7:0] ram_mem [2**RAM_AW];

  // Single port, owner picked by load mode
  logic [RAM_AW-1:0] ram_addr;
  logic [7:0]        ram_wdata;
  logic              ram_we;
  host_region_e      host_region;

  assign host_region = host_region_e'(i_host.addr[31:24]);

  // ==========================================================================
  // Port mux
  // ==========================================================================

  // Host owns the port while loading, CPU otherwise
  // CPU writes limited to RAM_BASE and up, once per enable
  always_comb begin
    if (i_load_mode) begin
      ram_addr  = i_host.addr[RAM_AW-1:0];
      ram_wdata = i_host.data;
      ram_we    = i_host.wr & (host_region == region_ram);
    end else begin
      ram_addr  = i_cpu_bus.addr[RAM_AW-1:0];
      ram_wdata = i_cpu_bus.wdata;
      ram_we    = i_sel.ram_wr_ok & i_cpu_ce;
    end
  end

  // ==========================================================================
  // Memory
  // ==========================================================================

  // Read returns old contents on a write cycle
  always_ff @(posedge clk_cpu) begin
    if (ram_we) begin
      ram_mem[ram_addr] <= ram_wdata;
    end
    o_data <= ram_mem[ram_addr];
  end

endmodule

// ==== src/host_control.sv ====
`timescale 1ns/1ns

module host_control
  import trs80_host_pkg::*;
(
  input  logic       clk_cpu,
  input  logic       pwr_up_reset_n,
  input  host_wr_t   i_host,
  input  logic       i_btn_wait,
  output logic       o_load_mode,
  output logic       o_ctrl_reset,
  output logic       o_cpu_wait_n,
  output logic [3:0] o_leds
);

  // Used control bits only
  logic [1:0]   ctrl_q;
  logic         btn_wait_q;
  host_region_e host_region;

  assign host_region = host_region_e'(i_host.addr[31:24]);

  // ==========================================================================
  // Control register
  // ==========================================================================

  // Written by host at region FF
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      ctrl_q <= '0;
    end else if (i_host.wr && host_region == region_ctrl) begin
      ctrl_q[CTRL_RESET_BIT] <= i_host.data[CTRL_RESET_BIT];
      ctrl_q[CTRL_LOAD_BIT]  <= i_host.data[CTRL_LOAD_BIT];
    end
  end

  assign o_ctrl_reset = ctrl_q[CTRL_RESET_BIT];
  assign o_load_mode  = ctrl_q[CTRL_LOAD_BIT];

  // Wait button, sampled into the clock domain
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      btn_wait_q <= 1'b0;
    end else begin
      btn_wait_q <= i_btn_wait;
    end
  end

  // CPU stalls while loading or on the button
  assign o_cpu_wait_n = ~(o_load_mode | btn_wait_q);

  // Status, bit 0 host read up to bit 3 reset
  assign o_leds = {o_ctrl_reset, o_load_mode, i_host.wr, i_host.rd};

endmodule

// ==== src/trs80_system.sv ====
`timescale 1ns/1ns

module trs80_system
  import trs80_bus_pkg::*;
  import trs80_host_pkg::*;
(
  input  logic       clk_cpu,
  input  logic       pwr_up_reset_n,
  // CPU bus, driven by the external core
  input  cpu_bus_t   i_cpu_bus,
  output logic [7:0] o_cpu_rdata,
  output logic       o_cpu_ce,
  output logic       o_cpu_reset_n,
  output logic       o_cpu_wait_n,
  // Host load port
  input  host_wr_t   i_host,
  output logic [7:0] o_host_rdata,
  // Buttons
  input  logic       i_btn_reset_n,
  input  logic       i_btn_wait,
  // Sound and status
  output audio_t     o_audio,
  output logic [3:0] o_leds
);

  // ==========================================================================
  // Internal wires
  // ==========================================================================

  dev_sel_t          sel;
  logic              load_mode;
  logic              ctrl_reset;
  logic [ROM_AW-1:0] rom_addr;
  logic [7:0]        rom_data;
  logic [7:0]        ram_data;

  // Host reads straight from the RAM port
  assign o_host_rdata = ram_data;

  // ==========================================================================
  // Instances
  // ==========================================================================

  cpu_timing cpu_timing_inst (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_btn_reset_n  (i_btn_reset_n),
    .i_ctrl_reset   (ctrl_reset),
    .o_cpu_ce       (o_cpu_ce),
    .o_cpu_reset_n  (o_cpu_reset_n)
  );

  bus_decode bus_decode_inst (
    .i_cpu_bus (i_cpu_bus),
    .o_sel     (sel)
  );

  io_ports io_ports_inst (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_cpu_ce       (o_cpu_ce),
    .i_sel          (sel),
    .i_wdata        (i_cpu_bus.wdata),
    .i_rom_data     (rom_data),
    .i_ram_data     (ram_data),
    .o_rom_addr     (rom_addr),
    .o_rdata        (o_cpu_rdata),
    .o_audio        (o_audio)
  );

  game_rom game_rom_inst (
    .clk_cpu (clk_cpu),
    .i_addr  (rom_addr),
    .o_data  (rom_data)
  );

  system_ram system_ram_inst (
    .clk_cpu     (clk_cpu),
    .i_cpu_ce    (o_cpu_ce),
    .i_sel       (sel),
    .i_cpu_bus   (i_cpu_bus),
    .i_host      (i_host),
    .i_load_mode (load_mode),
    .o_data      (ram_data)
  );

  host_control host_control_inst (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_host         (i_host),
    .i_btn_wait     (i_btn_wait),
    .o_load_mode    (load_mode),
    .o_ctrl_reset   (ctrl_reset),
    .o_cpu_wait_n   (o_cpu_wait_n),
    .o_leds         (o_leds)
  );

endmodule

// ==== tb/tb_trs80_system.sv ====
`timescale 1ns/1ns

module tb_trs80_system
  import trs80_bus_pkg::*;
  import trs80_host_pkg::*;
();

  // ==========================================================================
  // Table types
  // ==========================================================================

  // What a row does
  typedef enum logic [2:0] {
    op_mem_wr, op_mem_rd, op_io_wr, op_io_rd, op_host_wr, op_host_rd, op_wait
  } op_e;

  // Which output a row compares
  typedef enum logic [2:0] {
    chk_none, chk_cpu_rdata, chk_host_rdata, chk_audio, chk_wait_n, chk_reset_n, chk_leds
  } chk_e;

  // Host rows use the full address and CPU rows the low 16 bits
  // Wait rows carry button levels in data with bit 0 reset_n and bit 1 wait
  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [7:0]  data;
    chk_e        chk;
    logic [7:0]  expected;
  } row_t;

  // DUT ports
  logic       clk_cpu;
  logic       pwr_up_reset_n;
  cpu_bus_t   cpu_bus;
  host_wr_t   host;
  logic       btn_reset_n;
  logic       btn_wait;
  logic [7:0] cpu_rdata;
  logic       cpu_ce;
  logic       cpu_reset_n;
  logic       cpu_wait_n;
  logic [7:0] host_rdata;
  audio_t     audio;
  logic [3:0] leds;

  row_t rows[$];
  int   seed;
  int   cycle_count = 0;
  int   cycle_limit = 0;

  trs80_system trs80_system_inst (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .i_cpu_bus      (cpu_bus),
    .o_cpu_rdata    (cpu_rdata),
    .o_cpu_ce       (cpu_ce),
    .o_cpu_reset_n  (cpu_reset_n),
    .o_cpu_wait_n   (cpu_wait_n),
    .i_host         (host),
    .o_host_rdata   (host_rdata),
    .i_btn_reset_n  (btn_reset_n),
    .i_btn_wait     (btn_wait),
    .o_audio        (audio),
    .o_leds         (leds)
  );

  // 100 ns clock
  always #50 clk_cpu = ~clk_cpu;

  // Run limit set once the table is built
  always @(posedge clk_cpu) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Some tests failed");
      $fatal(1, "Simulation stopped by cycle limit");
    end
  end

  // ==========================================================================
  // Compare tasks
  // ==========================================================================

  task automatic check_byte(input string name, input logic [7:0] actual,
                            input logic [7:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_audio(input string name, input audio_t actual, input audio_t expected);
    if (actual !== expected) begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================

  function automatic logic [7:0] random_byte();
    logic [31:0] value;
    value = $random(seed);
    return value[7:0];
  endfunction

  // Region in the top byte
  function automatic logic [31:0] host_addr(input host_region_e region,
                                            input logic [15:0] addr);
    return {region, 8'h00, addr};
  endfunction

  task automatic add_row(input op_e op, input logic [31:0] addr, input logic [7:0] data,
                         input chk_e chk, input logic [7:0] expected);
    row_t r;
    r.op       = op;
    r.addr     = addr;
    r.data     = data;
    r.chk      = chk;
    r.expected = expected;
    rows.push_back(r);
  endtask

  // Returns 5 ns after a rising edge where inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_cpu);
    #5;
  endtask

  // Strobes held one full enable period and read data taken before release
  task automatic cpu_access(input logic is_io, input logic is_wr, input logic [15:0] addr,
                            input logic [7:0] data, output logic [7:0] rdata);
    cpu_bus.addr   = addr;
    cpu_bus.wdata  = data;
    cpu_bus.n_mreq = is_io;
    cpu_bus.n_iorq = ~is_io;
    cpu_bus.n_wr   = ~is_wr;
    cpu_bus.n_rd   = is_wr;
    wait_cycles(4);
    rdata          = cpu_rdata;
    cpu_bus.n_rd   = 1'b1;
    cpu_bus.n_wr   = 1'b1;
    cpu_bus.n_mreq = 1'b1;
    cpu_bus.n_iorq = 1'b1;
  endtask

  // Single cycle strobe with RAM data one cycle after the address
  // Strobe LEDs follow the host strobes while they are held
  task automatic host_access(input logic is_wr, input logic [31:0] addr,
                             input logic [7:0] data, output logic [7:0] rdata);
    host.addr = addr;
    host.data = data;
    host.wr   = is_wr;
    host.rd   = ~is_wr;
    wait_cycles(1);
    rdata     = host_rdata;
    check_bit("o_leds[1]", leds[1], is_wr);
    check_bit("o_leds[0]", leds[0], ~is_wr);
    host.wr   = 1'b0;
    host.rd   = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    logic [7:0] rdata;
    rdata = 8'h00;
    case (r.op)
      op_mem_wr:  cpu_access(1'b0, 1'b1, r.addr[15:0], r.data, rdata);
      op_mem_rd:  cpu_access(1'b0, 1'b0, r.addr[15:0], r.data, rdata);
      op_io_wr:   cpu_access(1'b1, 1'b1, r.addr[15:0], r.data, rdata);
      op_io_rd:   cpu_access(1'b1, 1'b0, r.addr[15:0], r.data, rdata);
      op_host_wr: host_access(1'b1, r.addr, r.data, rdata);
      op_host_rd: host_access(1'b0, r.addr, r.data, rdata);
      default: begin
        btn_reset_n = r.data[0];
        btn_wait    = r.data[1];
      end
    endcase
    if (r.chk == chk_cpu_rdata) begin
      check_byte("o_cpu_rdata", rdata, r.expected);
    end
    if (r.chk == chk_host_rdata) begin
      check_byte("o_host_rdata", rdata, r.expected);
    end
    // Idle gap so registered levels settle and the read detector rearms
    wait_cycles(4);
    case (r.chk)
      chk_audio:   check_audio("o_audio", audio, r.expected[3:0]);
      chk_wait_n:  check_bit("o_cpu_wait_n", cpu_wait_n, r.expected[0]);
      chk_reset_n: check_bit("o_cpu_reset_n", cpu_reset_n, r.expected[0]);
      chk_leds:    check_byte("o_leds", {4'h0, leds}, r.expected);
      default: ;
    endcase
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    logic [7:0] rnd [6];
    int         ce_high;
    clk_cpu        = 1'b0;
    pwr_up_reset_n = 1'b0;
    cpu_bus.n_rd   = 1'b1;
    cpu_bus.n_wr   = 1'b1;
    cpu_bus.n_mreq = 1'b1;
    cpu_bus.n_iorq = 1'b1;
    cpu_bus.addr   = 16'h0000;
    cpu_bus.wdata  = 8'h00;
    host           = '0;
    btn_reset_n    = 1'b1;
    btn_wait       = 1'b0;
    seed           = 63;
    ce_high        = 0;
    for (int i = 0; i < 6; i++) begin
      rnd[i] = random_byte();
    end

    // Host load stalls the CPU while the load bit is set
    add_row(op_host_wr, host_addr(region_ctrl, 16'h0000), 8'h02, chk_wait_n, 8'h00);
    // Load mode LED on
    add_row(op_wait, 32'h0000_0000, 8'h01, chk_leds, 8'h04);
    add_row(op_host_wr, host_addr(region_ram, 16'h0100), rnd[0], chk_none, 8'h00);
    add_row(op_host_wr, host_addr(region_ram, 16'h1234), rnd[1], chk_none, 8'h00);
    add_row(op_host_wr, host_addr(region_ram, 16'h2FFF), rnd[2], chk_none, 8'h00);
    add_row(op_host_rd, host_addr(region_ram, 16'h0100), 8'h00, chk_host_rdata, rnd[0]);
    add_row(op_host_rd, host_addr(region_ram, 16'h1234), 8'h00, chk_host_rdata, rnd[1]);
    add_row(op_host_rd, host_addr(region_ram, 16'h2FFF), 8'h00, chk_host_rdata, rnd[2]);
    add_row(op_host_wr, host_addr(region_ctrl, 16'h0000), 8'h00, chk_wait_n, 8'h01);

    // CPU RAM writable from 3000 up only
    add_row(op_mem_wr, 32'h0000_3000, rnd[3], chk_none, 8'h00);
    add_row(op_mem_rd, 32'h0000_3000, 8'h00, chk_cpu_rdata, rnd[3]);
    add_row(op_mem_wr, 32'h0000_FFFF, rnd[4], chk_none, 8'h00);
    add_row(op_mem_rd, 32'h0000_FFFF, 8'h00, chk_cpu_rdata, rnd[4]);
    add_row(op_mem_wr, 32'h0000_0100, ~rnd[0], chk_none, 8'h00);
    add_row(op_mem_rd, 32'h0000_0100, 8'h00, chk_cpu_rdata, rnd[0]);
    add_row(op_mem_wr, 32'h0000_2FFF, ~rnd[2], chk_none, 8'h00);
    add_row(op_mem_rd, 32'h0000_2FFF, 8'h00, chk_cpu_rdata, rnd[2]);

    // OUT 4 rewinds the game stream and each IN 4 takes the next byte
    add_row(op_io_wr, 32'h0000_0004, rnd[5], chk_none, 8'h00);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA0);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA1);
    add_row(op_io_rd, 32'h0000_5504, 8'h00, chk_cpu_rdata, 8'hA2);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA3);
    // Motor off then on rewinds
    add_row(op_io_wr, 32'h0000_00FF, 8'h00, chk_audio, 8'h04);
    add_row(op_io_wr, 32'h0000_00FF, 8'h04, chk_audio, 8'h04);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA0);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA1);
    // No rewind with motor already on
    add_row(op_io_wr, 32'h0000_00FF, 8'h04, chk_audio, 8'h04);
    add_row(op_io_rd, 32'h0000_0004, 8'h00, chk_cpu_rdata, 8'hA2);

    // Sound levels from data bits 1:0
    add_row(op_io_wr, 32'h0000_00FF, 8'h00, chk_audio, 8'h04);
    add_row(op_io_wr, 32'h0000_00FF, 8'h01, chk_audio, 8'h08);
    add_row(op_io_wr, 32'h0000_00FF, 8'h02, chk_audio, 8'h00);
    add_row(op_io_wr, 32'h0000_00FF, 8'h03, chk_audio, 8'h04);
    // Other port leaves the level alone
    add_row(op_io_wr, 32'h0000_0010, 8'h01, chk_audio, 8'h04);

    // Reset sources in turn from control bit and button
    add_row(op_host_wr, host_addr(region_ctrl, 16'h0000), 8'h01, chk_reset_n, 8'h00);
    // Reset LED on
    add_row(op_wait, 32'h0000_0000, 8'h01, chk_leds, 8'h08);
    add_row(op_host_wr, host_addr(region_ctrl, 16'h0000), 8'h00, chk_reset_n, 8'h01);
    add_row(op_wait, 32'h0000_0000, 8'h00, chk_reset_n, 8'h00);
    add_row(op_wait, 32'h0000_0000, 8'h01, chk_reset_n, 8'h01);

    // Wait button
    add_row(op_wait, 32'h0000_0000, 8'h03, chk_wait_n, 8'h00);
    add_row(op_wait, 32'h0000_0000, 8'h01, chk_wait_n, 8'h01);
    // RAM contents survive the CPU resets
    add_row(op_mem_rd, 32'h0000_3000, 8'h00, chk_cpu_rdata, rnd[3]);

    // At most 8 cycles per row
    cycle_limit = rows.size() * 8 + 50;

    // Power-up reset for three cycles
    wait_cycles(3);
    check_bit("o_cpu_reset_n", cpu_reset_n, 1'b0);
    pwr_up_reset_n = 1'b1;
    wait_cycles(1);
    check_bit("o_cpu_reset_n", cpu_reset_n, 1'b1);
    check_audio("o_audio", audio, 4'd0);
    check_bit("o_cpu_wait_n", cpu_wait_n, 1'b1);

    // Clock enable high two cycles in every four
    for (int i = 0; i < 4; i++) begin
      if (cpu_ce === 1'b1) begin
        ce_high++;
      end
      wait_cycles(1);
    end
    check_byte("o_cpu_ce high cycles", 8'(ce_high), 8'd2);

    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== game_rom.mem ====
// One hex byte per line, game stream data from ROM address 0
A0
A1
A2
A3
A4
A5
A6
A7
A8
A9
AA
AB
AC
AD
AE
AF

// ==== vlog.f ====
src/trs80_bus_pkg.sv
src/trs80_host_pkg.sv
src/cpu_timing.sv
src/bus_decode.sv
src/io_ports.sv
src/game_rom.sv
src/system_ram.sv
src/host_control.sv
src/trs80_system.sv
tb/tb_trs80_system.sv

// ==== Makefile ====
TOP := tb_trs80_system

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^All tests passed$$" > /dev/null

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir
